/* rtl/la_decode_pkg.sv */
package la_decode_pkg;

  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_NUM_W  = 14;
  localparam int INST_ID_W  = 6;
  localparam int ALU_OP_W   = 5;
  localparam int NPC_OP_W   = 5;
  localparam int WD_SEL_W   = 2;
  localparam int DM_TYPE_W  = 3;

  //////////////////////////////////////////////////
  // instruction identifiers

  localparam logic [INST_ID_W-1:0]
    ID_NONE      = 6'd0,   // no pattern matched
    ID_ADD_W     = 6'd1,
    ID_SUB_W     = 6'd2,
    ID_SLT       = 6'd3,
    ID_SLTU      = 6'd4,
    ID_NOR       = 6'd5,
    ID_AND       = 6'd6,
    ID_OR        = 6'd7,
    ID_XOR       = 6'd8,
    ID_SLL_W     = 6'd9,
    ID_SRL_W     = 6'd10,
    ID_SRA_W     = 6'd11,
    ID_MUL_W     = 6'd12,
    ID_MULH_W    = 6'd13,
    ID_MULH_WU   = 6'd14,
    ID_DIV_W     = 6'd15,
    ID_MOD_W     = 6'd16,
    ID_DIV_WU    = 6'd17,
    ID_MOD_WU    = 6'd18,
    ID_SLLI_W    = 6'd19,
    ID_SRLI_W    = 6'd20,
    ID_SRAI_W    = 6'd21,
    ID_ADDI_W    = 6'd22,
    ID_SLTI      = 6'd23,
    ID_SLTUI     = 6'd24,
    ID_ANDI      = 6'd25,
    ID_ORI       = 6'd26,
    ID_XORI      = 6'd27,
    ID_LU12I_W   = 6'd28,
    ID_PCADDU12I = 6'd29,
    ID_LD_B      = 6'd30,
    ID_LD_H      = 6'd31,
    ID_LD_W      = 6'd32,
    ID_LD_BU     = 6'd33,
    ID_LD_HU     = 6'd34,
    ID_ST_B      = 6'd35,
    ID_ST_H      = 6'd36,
    ID_ST_W      = 6'd37,
    ID_JIRL      = 6'd38,
    ID_B         = 6'd39,
    ID_BL        = 6'd40,
    ID_BEQ       = 6'd41,
    ID_BNE       = 6'd42,
    ID_BLT       = 6'd43,
    ID_BGE       = 6'd44,
    ID_BLTU      = 6'd45,
    ID_BGEU      = 6'd46,
    ID_CSRRD     = 6'd47,
    ID_CSRWR     = 6'd48,
    ID_CSRXCHG   = 6'd49,
    ID_ERTN      = 6'd50,
    ID_BREAK     = 6'd51,
    ID_SYSCALL   = 6'd52;

  //////////////////////////////////////////////////
  // execute stage codes

  localparam logic [ALU_OP_W-1:0]
    ALU_NOP    = 5'b00000,
    ALU_LUI    = 5'b00001,
    ALU_ADD    = 5'b00011,
    ALU_SUB    = 5'b00100,
    ALU_BNE    = 5'b00101,
    ALU_BLT    = 5'b00110,
    ALU_BGE    = 5'b00111,
    ALU_BLTU   = 5'b01000,
    ALU_BGEU   = 5'b01001,
    ALU_SLT    = 5'b01010,
    ALU_SLTU   = 5'b01011,
    ALU_XOR    = 5'b01100,
    ALU_OR     = 5'b01101,
    ALU_AND    = 5'b01110,
    ALU_SLL    = 5'b01111,
    ALU_SRL    = 5'b10000,
    ALU_SRA    = 5'b10001,
    ALU_NOR    = 5'b10010,
    ALU_BEQ    = 5'b10011,
    ALU_MULW   = 5'b10100,
    ALU_MULHW  = 5'b10101,
    ALU_MULHWU = 5'b10110,
    ALU_DIVW   = 5'b10111,
    ALU_MODW   = 5'b11000,
    ALU_DIVWU  = 5'b11001,
    ALU_MODWU  = 5'b11010,
    ALU_CSR    = 5'b11011;   // csr read / write path

  localparam logic [NPC_OP_W-1:0]
    NPC_PLUS4  = 5'b00000,
    NPC_BRANCH = 5'b00001,   // conditional, taken in ex
    NPC_B      = 5'b00110,
    NPC_ERTN   = 5'b01000,
    NPC_JIRL   = 5'b11000;

  localparam logic [WD_SEL_W-1:0]
    WD_ALU = 2'b00,
    WD_MEM = 2'b01,
    WD_PC  = 2'b10;          // link address

  localparam logic [DM_TYPE_W-1:0]
    DM_WORD   = 3'b000,
    DM_HALF   = 3'b001,
    DM_HALF_U = 3'b010,
    DM_BYTE   = 3'b011,
    DM_BYTE_U = 3'b100;

  localparam logic [INST_W-1:0] IMM_FOUR = 32'd4;   // pc + 4 for links

  // one word, two field layouts
  typedef union packed {
    struct packed {
      logic [16:0]           op;   // bits 31..15
      logic [REG_ADDR_W-1:0] rk;
      logic [REG_ADDR_W-1:0] rj;
      logic [REG_ADDR_W-1:0] rd;
    } r;
    struct packed {
      logic [5:0]  op;             // bits 31..26
      logic [15:0] offs;           // si16, low half of si26
      logic [9:0]  lo;             // high part of si26
    } i;
  } la_inst_u;

endpackage

/* rtl/la_opcode_decode.sv */
module la_opcode_decode
  import la_decode_pkg::*;
(
  input  la_inst_u             i_inst,
  output logic [INST_ID_W-1:0] o_inst_id
);

  // item layout is {31..26, 25..22, 21..20, 19..15}
  always_comb begin
    o_inst_id = ID_NONE;
    casez (i_inst.r.op)
      // 3r group
      {6'h00, 4'h0, 2'h1, 5'h00}: o_inst_id = ID_ADD_W;
      {6'h00, 4'h0, 2'h1, 5'h02}: o_inst_id = ID_SUB_W;
      {6'h00, 4'h0, 2'h1, 5'h04}: o_inst_id = ID_SLT;
      {6'h00, 4'h0, 2'h1, 5'h05}: o_inst_id = ID_SLTU;
      {6'h00, 4'h0, 2'h1, 5'h08}: o_inst_id = ID_NOR;
      {6'h00, 4'h0, 2'h1, 5'h09}: o_inst_id = ID_AND;
      {6'h00, 4'h0, 2'h1, 5'h0a}: o_inst_id = ID_OR;
      {6'h00, 4'h0, 2'h1, 5'h0b}: o_inst_id = ID_XOR;
      {6'h00, 4'h0, 2'h1, 5'h0e}: o_inst_id = ID_SLL_W;
      {6'h00, 4'h0, 2'h1, 5'h0f}: o_inst_id = ID_SRL_W;
      {6'h00, 4'h0, 2'h1, 5'h10}: o_inst_id = ID_SRA_W;
      {6'h00, 4'h0, 2'h1, 5'h18}: o_inst_id = ID_MUL_W;
      {6'h00, 4'h0, 2'h1, 5'h19}: o_inst_id = ID_MULH_W;
      {6'h00, 4'h0, 2'h1, 5'h1a}: o_inst_id = ID_MULH_WU;
      {6'h00, 4'h0, 2'h2, 5'h00}: o_inst_id = ID_DIV_W;
      {6'h00, 4'h0, 2'h2, 5'h01}: o_inst_id = ID_MOD_W;
      {6'h00, 4'h0, 2'h2, 5'h02}: o_inst_id = ID_DIV_WU;
      {6'h00, 4'h0, 2'h2, 5'h03}: o_inst_id = ID_MOD_WU;
      {6'h00, 4'h0, 2'h2, 5'h14}: o_inst_id = ID_BREAK;
      {6'h00, 4'h0, 2'h2, 5'h16}: o_inst_id = ID_SYSCALL;

      // shift by ui5
      {6'h00, 4'h1, 2'h0, 5'h01}: o_inst_id = ID_SLLI_W;
      {6'h00, 4'h1, 2'h0, 5'h09}: o_inst_id = ID_SRLI_W;
      {6'h00, 4'h1, 2'h0, 5'h11}: o_inst_id = ID_SRAI_W;

      // 2ri12, low 7 bits belong to the immediate
      {6'h00, 4'h8, 7'b?}: o_inst_id = ID_SLTI;
      {6'h00, 4'h9, 7'b?}: o_inst_id = ID_SLTUI;
      {6'h00, 4'ha, 7'b?}: o_inst_id = ID_ADDI_W;
      {6'h00, 4'hd, 7'b?}: o_inst_id = ID_ANDI;
      {6'h00, 4'he, 7'b?}: o_inst_id = ID_ORI;
      {6'h00, 4'hf, 7'b?}: o_inst_id = ID_XORI;

      {6'h05, 1'b0, 10'b?}: o_inst_id = ID_LU12I_W;   // bit 25 clear
      {6'h07, 1'b0, 10'b?}: o_inst_id = ID_PCADDU12I;

      // loads and stores
      {6'h0a, 4'h0, 7'b?}: o_inst_id = ID_LD_B;
      {6'h0a, 4'h1, 7'b?}: o_inst_id = ID_LD_H;
      {6'h0a, 4'h2, 7'b?}: o_inst_id = ID_LD_W;
      {6'h0a, 4'h4, 7'b?}: o_inst_id = ID_ST_B;
      {6'h0a, 4'h5, 7'b?}: o_inst_id = ID_ST_H;
      {6'h0a, 4'h6, 7'b?}: o_inst_id = ID_ST_W;
      {6'h0a, 4'h8, 7'b?}: o_inst_id = ID_LD_BU;
      {6'h0a, 4'h9, 7'b?}: o_inst_id = ID_LD_HU;

      // jumps and branches, top six bits only
      {6'h13, 11'b?}: o_inst_id = ID_JIRL;
      {6'h14, 11'b?}: o_inst_id = ID_B;
      {6'h15, 11'b?}: o_inst_id = ID_BL;
      {6'h16, 11'b?}: o_inst_id = ID_BEQ;
      {6'h17, 11'b?}: o_inst_id = ID_BNE;
      {6'h18, 11'b?}: o_inst_id = ID_BLT;
      {6'h19, 11'b?}: o_inst_id = ID_BGE;
      {6'h1a, 11'b?}: o_inst_id = ID_BLTU;
      {6'h1b, 11'b?}: o_inst_id = ID_BGEU;

      // csr group, rj picks the flavour
      {6'h01, 2'b00, 9'b?}: o_inst_id = (i_inst.r.rj == 5'd0) ? ID_CSRRD :
                                        (i_inst.r.rj == 5'd1) ? ID_CSRWR : ID_CSRXCHG;
      {6'h01, 4'h9, 2'h0, 5'h10}: o_inst_id = (i_inst.r.rk == 5'h0e) ? ID_ERTN : ID_NONE;
      default: o_inst_id = ID_NONE;
    endcase
  end

endmodule

/* rtl/la_field_extract.sv */
module la_field_extract
  import la_decode_pkg::*;
(
  input  la_inst_u              i_inst,
  input  logic [INST_ID_W-1:0]  i_inst_id,
  output logic [INST_W-1:0]     o_imm_alu,
  output logic [INST_W-1:0]     o_imm_pc,
  output logic [REG_ADDR_W-1:0] o_rd,
  output logic [REG_ADDR_W-1:0] o_rs1,
  output logic [REG_ADDR_W-1:0] o_rs2,
  output logic [CSR_NUM_W-1:0]  o_csr_num
);

  logic [19:0]       si20;
  logic [11:0]       i12;
  logic [INST_W-1:0] si16_x4;
  logic [INST_W-1:0] si26_x4;
  logic              need_four, need_si20, need_si16, need_si26, need_ui5, need_ui12;
  logic              rs2_is_rd;

  assign si20    = {i_inst.r.op[9:0], i_inst.r.rk, i_inst.r.rj};   // bits 24..5
  assign i12     = {i_inst.r.op[6:0], i_inst.r.rk};                // bits 21..10
  assign si16_x4 = {{14{i_inst.i.offs[15]}}, i_inst.i.offs, 2'b00};
  assign si26_x4 = {{4{i_inst.i.lo[9]}}, i_inst.i.lo, i_inst.i.offs, 2'b00};

  assign need_four = i_inst_id inside {ID_JIRL, ID_BL};
  assign need_si20 = i_inst_id inside {ID_LU12I_W, ID_PCADDU12I};
  assign need_si16 = i_inst_id inside {ID_JIRL, ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_BLTU,
                                       ID_BGEU};
  assign need_si26 = i_inst_id inside {ID_B, ID_BL};
  assign need_ui5  = i_inst_id inside {ID_SLLI_W, ID_SRLI_W, ID_SRAI_W};
  assign need_ui12 = i_inst_id inside {ID_ANDI, ID_ORI, ID_XORI};

  // first match wins, si12 is the fallback
  assign o_imm_alu = need_four ? IMM_FOUR              :
                     need_si20 ? {si20, 12'b0}         :
                     need_si16 ? si16_x4               :
                     need_si26 ? si26_x4               :
                     need_ui5  ? {27'b0, i_inst.r.rk}  :
                     need_ui12 ? {20'b0, i12}          :
                                 {{20{i12[11]}}, i12};

  assign o_imm_pc = need_si26 ? si26_x4 :
                    need_si16 ? si16_x4 : '0;

  // second read port carries rd when rd is a source
  assign rs2_is_rd = i_inst_id inside {ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_BLTU, ID_BGEU,
                                       ID_ST_B, ID_ST_H, ID_ST_W, ID_CSRWR, ID_CSRXCHG};

  assign o_rd      = (i_inst_id == ID_BL) ? 5'd1 : i_inst.r.rd;   // bl links into r1
  assign o_rs1     = i_inst.r.rj;
  assign o_rs2     = rs2_is_rd ? i_inst.r.rd : i_inst.r.rk;
  assign o_csr_num = {i_inst.r.op[8:0], i_inst.r.rk};             // bits 23..10

endmodule

/* rtl/la_ctrl_gen.sv */
module la_ctrl_gen
  import la_decode_pkg::*;
(
  input  logic [INST_ID_W-1:0] i_inst_id,
  output logic [ALU_OP_W-1:0]  o_alu_op,
  output logic [NPC_OP_W-1:0]  o_npc_op,
  output logic [WD_SEL_W-1:0]  o_wd_sel,
  output logic [DM_TYPE_W-1:0] o_dm_type,
  output logic                 o_reg_write,
  output logic                 o_mem_write,
  output logic                 o_mem_read,
  output logic                 o_alu_src1,
  output logic                 o_alu_src2,
  output logic                 o_csr_write,
  output logic                 o_csr_mask_en,
  output logic                 o_ertn,
  output logic                 o_syscall
);

  logic is_load, is_store, is_cond_br;

  assign is_load    = i_inst_id inside {ID_LD_B, ID_LD_H, ID_LD_W, ID_LD_BU, ID_LD_HU};
  assign is_store   = i_inst_id inside {ID_ST_B, ID_ST_H, ID_ST_W};
  assign is_cond_br = i_inst_id inside {ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_BLTU, ID_BGEU};

  //////////////////////////////////////////////////
  // enables and operand selects

  assign o_mem_read  = is_load;
  assign o_mem_write = is_store;
  assign o_reg_write = (i_inst_id != ID_NONE) && !is_store && !is_cond_br &&
                       (i_inst_id != ID_B);
  assign o_alu_src1  = i_inst_id inside {ID_JIRL, ID_BL, ID_PCADDU12I};   // pc as operand a
  assign o_alu_src2  = is_load || is_store ||
                       i_inst_id inside {ID_SLLI_W, ID_SRLI_W, ID_SRAI_W, ID_ADDI_W, ID_SLTI,
                                         ID_SLTUI, ID_ANDI, ID_ORI, ID_XORI, ID_LU12I_W,
                                         ID_JIRL, ID_BL, ID_PCADDU12I};

  assign o_csr_write   = i_inst_id inside {ID_CSRWR, ID_CSRXCHG};
  assign o_csr_mask_en = (i_inst_id == ID_CSRXCHG);
  assign o_ertn        = (i_inst_id == ID_ERTN);
  assign o_syscall     = (i_inst_id == ID_SYSCALL);

  //////////////////////////////////////////////////
  // alu, next pc and access size

  always_comb begin
    o_alu_op  = ALU_NOP;
    o_npc_op  = is_cond_br ? NPC_BRANCH : NPC_PLUS4;
    o_wd_sel  = is_load ? WD_MEM :
                (i_inst_id inside {ID_JIRL, ID_BL}) ? WD_PC : WD_ALU;
    o_dm_type = DM_WORD;
    case (i_inst_id)
      ID_ADD_W, ID_ADDI_W, ID_PCADDU12I, ID_LD_W, ID_ST_W: o_alu_op = ALU_ADD;
      ID_SUB_W:             o_alu_op = ALU_SUB;
      ID_SLT, ID_SLTI:      o_alu_op = ALU_SLT;
      ID_SLTU, ID_SLTUI:    o_alu_op = ALU_SLTU;
      ID_NOR:               o_alu_op = ALU_NOR;
      ID_AND, ID_ANDI:      o_alu_op = ALU_AND;
      ID_OR, ID_ORI:        o_alu_op = ALU_OR;
      ID_XOR, ID_XORI:      o_alu_op = ALU_XOR;
      ID_SLL_W, ID_SLLI_W:  o_alu_op = ALU_SLL;
      ID_SRL_W, ID_SRLI_W:  o_alu_op = ALU_SRL;
      ID_SRA_W, ID_SRAI_W:  o_alu_op = ALU_SRA;
      ID_LU12I_W:           o_alu_op = ALU_LUI;
      ID_MUL_W:             o_alu_op = ALU_MULW;
      ID_MULH_W:            o_alu_op = ALU_MULHW;
      ID_MULH_WU:           o_alu_op = ALU_MULHWU;
      ID_DIV_W:             o_alu_op = ALU_DIVW;
      ID_MOD_W:             o_alu_op = ALU_MODW;
      ID_DIV_WU:            o_alu_op = ALU_DIVWU;
      ID_MOD_WU:            o_alu_op = ALU_MODWU;
      ID_LD_H, ID_ST_H: begin
        o_alu_op  = ALU_ADD;
        o_dm_type = DM_HALF;
      end
      ID_LD_HU: begin
        o_alu_op  = ALU_ADD;
        o_dm_type = DM_HALF_U;
      end
      ID_LD_B, ID_ST_B: begin
        o_alu_op  = ALU_ADD;
        o_dm_type = DM_BYTE;
      end
      ID_LD_BU: begin
        o_alu_op  = ALU_ADD;
        o_dm_type = DM_BYTE_U;
      end
      ID_JIRL: begin
        o_alu_op = ALU_ADD;   // link value pc + 4
        o_npc_op = NPC_JIRL;
      end
      ID_B, ID_BL: begin
        o_alu_op = ALU_ADD;
        o_npc_op = NPC_B;
      end
      ID_BEQ:               o_alu_op = ALU_BEQ;   // compare result drives the branch
      ID_BNE:               o_alu_op = ALU_BNE;
      ID_BLT:               o_alu_op = ALU_BLT;
      ID_BGE:               o_alu_op = ALU_BGE;
      ID_BLTU:              o_alu_op = ALU_BLTU;
      ID_BGEU:              o_alu_op = ALU_BGEU;
      ID_CSRRD, ID_CSRWR, ID_CSRXCHG: o_alu_op = ALU_CSR;
      ID_ERTN:              o_npc_op = NPC_ERTN;
      default:              o_alu_op = ALU_NOP;
    endcase
  end

endmodule

/* rtl/la_id_pipe_reg.sv */
module la_id_pipe_reg
  import la_decode_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_valid,
  input  logic [ALU_OP_W-1:0]   i_alu_op,
  input  logic [NPC_OP_W-1:0]   i_npc_op,
  input  logic [WD_SEL_W-1:0]   i_wd_sel,
  input  logic [DM_TYPE_W-1:0]  i_dm_type,
  input  logic                  i_reg_write, i_mem_write, i_mem_read,
  input  logic                  i_alu_src1, i_alu_src2,
  input  logic                  i_csr_write, i_csr_mask_en,
  input  logic                  i_ertn, i_syscall,
  input  logic [INST_W-1:0]     i_imm_alu, i_imm_pc,
  input  logic [REG_ADDR_W-1:0] i_rd, i_rs1, i_rs2,
  input  logic [CSR_NUM_W-1:0]  i_csr_num,
  output logic                  o_valid,
  output logic [ALU_OP_W-1:0]   o_alu_op,
  output logic [NPC_OP_W-1:0]   o_npc_op,
  output logic [WD_SEL_W-1:0]   o_wd_sel,
  output logic [DM_TYPE_W-1:0]  o_dm_type,
  output logic                  o_reg_write, o_mem_write, o_mem_read,
  output logic                  o_alu_src1, o_alu_src2,
  output logic                  o_csr_write, o_csr_mask_en,
  output logic                  o_ertn, o_syscall,
  output logic [INST_W-1:0]     o_imm_alu, o_imm_pc,
  output logic [REG_ADDR_W-1:0] o_rd, o_rs1, o_rs2,
  output logic [CSR_NUM_W-1:0]  o_csr_num
);

  // side-effect strobes drop to 0 on an empty slot
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid     <= 1'b0;
      o_reg_write <= 1'b0;
      o_mem_write <= 1'b0;
      o_csr_write <= 1'b0;
      o_ertn      <= 1'b0;
      o_syscall   <= 1'b0;
    end else begin
      o_valid     <= i_valid;
      o_reg_write <= i_valid & i_reg_write;
      o_mem_write <= i_valid & i_mem_write;
      o_csr_write <= i_valid & i_csr_write;
      o_ertn      <= i_valid & i_ertn;
      o_syscall   <= i_valid & i_syscall;
    end
  end

  // decoded fields hold while no word arrives
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_alu_op      <= '0;
      o_npc_op      <= '0;
      o_wd_sel      <= '0;
      o_dm_type     <= '0;
      o_mem_read    <= 1'b0;
      o_alu_src1    <= 1'b0;
      o_alu_src2    <= 1'b0;
      o_csr_mask_en <= 1'b0;
      o_imm_alu     <= '0;
      o_imm_pc      <= '0;
      o_rd          <= '0;
      o_rs1         <= '0;
      o_rs2         <= '0;
      o_csr_num     <= '0;
    end else if (i_valid) begin
      o_alu_op      <= i_alu_op;
      o_npc_op      <= i_npc_op;
      o_wd_sel      <= i_wd_sel;
      o_dm_type     <= i_dm_type;
      o_mem_read    <= i_mem_read;
      o_alu_src1    <= i_alu_src1;
      o_alu_src2    <= i_alu_src2;
      o_csr_mask_en <= i_csr_mask_en;
      o_imm_alu     <= i_imm_alu;
      o_imm_pc      <= i_imm_pc;
      o_rd          <= i_rd;
      o_rs1         <= i_rs1;
      o_rs2         <= i_rs2;
      o_csr_num     <= i_csr_num;
    end
  end

endmodule

/* rtl/la_decode_top.sv */
module la_decode_top
  import la_decode_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_valid,
  input  logic [INST_W-1:0]     i_inst,
  output logic                  o_valid,
  output logic [ALU_OP_W-1:0]   o_alu_op,
  output logic [NPC_OP_W-1:0]   o_npc_op,
  output logic [WD_SEL_W-1:0]   o_wd_sel,
  output logic [DM_TYPE_W-1:0]  o_dm_type,
  output logic                  o_reg_write, o_mem_write, o_mem_read,
  output logic                  o_alu_src1, o_alu_src2,
  output logic                  o_csr_write, o_csr_mask_en,
  output logic                  o_ertn, o_syscall,
  output logic [INST_W-1:0]     o_imm_alu, o_imm_pc,
  output logic [REG_ADDR_W-1:0] o_rd, o_rs1, o_rs2,
  output logic [CSR_NUM_W-1:0]  o_csr_num
);

  logic [INST_ID_W-1:0]  inst_id;
  logic [ALU_OP_W-1:0]   alu_op;
  logic [NPC_OP_W-1:0]   npc_op;
  logic [WD_SEL_W-1:0]   wd_sel;
  logic [DM_TYPE_W-1:0]  dm_type;
  logic                  reg_write, mem_write, mem_read, alu_src1, alu_src2;
  logic                  csr_write, csr_mask_en, ertn, syscall;
  logic [INST_W-1:0]     imm_alu, imm_pc;
  logic [REG_ADDR_W-1:0] rd, rs1, rs2;
  logic [CSR_NUM_W-1:0]  csr_num;

  la_opcode_decode u_opcode_decode (
    .i_inst    (i_inst),
    .o_inst_id (inst_id)
  );

  la_field_extract u_field_extract (
    .i_inst    (i_inst),
    .i_inst_id (inst_id),
    .o_imm_alu (imm_alu), .o_imm_pc (imm_pc),
    .o_rd      (rd), .o_rs1 (rs1), .o_rs2 (rs2),
    .o_csr_num (csr_num)
  );

  la_ctrl_gen u_ctrl_gen (
    .i_inst_id   (inst_id),
    .o_alu_op    (alu_op), .o_npc_op (npc_op), .o_wd_sel (wd_sel), .o_dm_type (dm_type),
    .o_reg_write (reg_write), .o_mem_write (mem_write), .o_mem_read (mem_read),
    .o_alu_src1  (alu_src1), .o_alu_src2 (alu_src2),
    .o_csr_write (csr_write), .o_csr_mask_en (csr_mask_en),
    .o_ertn      (ertn), .o_syscall (syscall)
  );

  // single register stage toward execute
  la_id_pipe_reg u_id_pipe_reg (
    .clk, .i_rst_n, .i_valid,
    .i_alu_op    (alu_op), .i_npc_op (npc_op), .i_wd_sel (wd_sel), .i_dm_type (dm_type),
    .i_reg_write (reg_write), .i_mem_write (mem_write), .i_mem_read (mem_read),
    .i_alu_src1  (alu_src1), .i_alu_src2 (alu_src2),
    .i_csr_write (csr_write), .i_csr_mask_en (csr_mask_en),
    .i_ertn      (ertn), .i_syscall (syscall),
    .i_imm_alu   (imm_alu), .i_imm_pc (imm_pc),
    .i_rd        (rd), .i_rs1 (rs1), .i_rs2 (rs2), .i_csr_num (csr_num),
    .o_valid, .o_alu_op, .o_npc_op, .o_wd_sel, .o_dm_type,
    .o_reg_write, .o_mem_write, .o_mem_read, .o_alu_src1, .o_alu_src2,
    .o_csr_write, .o_csr_mask_en, .o_ertn, .o_syscall,
    .o_imm_alu, .o_imm_pc, .o_rd, .o_rs1, .o_rs2, .o_csr_num
  );

endmodule

/* tb/tb_la_decode.sv */
module tb_la_decode
  import la_decode_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NCOL       = 22;   // inst, valid, then 20 expected outputs
  localparam int MAX_ROWS   = 64;
  localparam int RST_CYCLES = 5;

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_valid;
  logic [INST_W-1:0]     i_inst;
  logic                  o_valid;
  logic [ALU_OP_W-1:0]   o_alu_op;
  logic [NPC_OP_W-1:0]   o_npc_op;
  logic [WD_SEL_W-1:0]   o_wd_sel;
  logic [DM_TYPE_W-1:0]  o_dm_type;
  logic                  o_reg_write, o_mem_write, o_mem_read;
  logic                  o_alu_src1, o_alu_src2;
  logic                  o_csr_write, o_csr_mask_en;
  logic                  o_ertn, o_syscall;
  logic [INST_W-1:0]     o_imm_alu, o_imm_pc;
  logic [REG_ADDR_W-1:0] o_rd, o_rs1, o_rs2;
  logic [CSR_NUM_W-1:0]  o_csr_num;

  logic [31:0] gold [MAX_ROWS][NCOL];
  int          n_rows      = 0;
  int          cycle_count = 0;
  int          cycle_limit = RST_CYCLES + 20;

  la_decode_top DUT (
    .clk, .i_rst_n, .i_valid, .i_inst,
    .o_valid, .o_alu_op, .o_npc_op, .o_wd_sel, .o_dm_type,
    .o_reg_write, .o_mem_write, .o_mem_read, .o_alu_src1, .o_alu_src2,
    .o_csr_write, .o_csr_mask_en, .o_ertn, .o_syscall,
    .o_imm_alu, .o_imm_pc, .o_rd, .o_rs1, .o_rs2, .o_csr_num
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // watchdog limit is set once the golden file is in
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("TEST FAILED");
      $fatal(1, "run did not finish within %0d clock cycles", cycle_limit);
    end
  end

  //////////////////////////////////////////////////
  // golden file and checks

  task automatic load_golden();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("tb/la_decode_golden.txt", "r");
    if (fd == 0) begin
      $display("TEST FAILED");
      $fatal(1, "cannot open the golden file tb/la_decode_golden.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin   // skip blanks and comments
        if (n_rows >= MAX_ROWS) begin
          $display("TEST FAILED");
          $fatal(1, "golden file holds more than %0d test lines", MAX_ROWS);
        end
        cnt = $sscanf(line,
          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          gold[n_rows][0], gold[n_rows][1], gold[n_rows][2], gold[n_rows][3],
          gold[n_rows][4], gold[n_rows][5], gold[n_rows][6], gold[n_rows][7],
          gold[n_rows][8], gold[n_rows][9], gold[n_rows][10], gold[n_rows][11],
          gold[n_rows][12], gold[n_rows][13], gold[n_rows][14], gold[n_rows][15],
          gold[n_rows][16], gold[n_rows][17], gold[n_rows][18], gold[n_rows][19],
          gold[n_rows][20], gold[n_rows][21]);
        if (cnt != NCOL) begin
          $display("TEST FAILED");
          $fatal(1, "golden line %0d has %0d columns instead of %0d", n_rows, cnt, NCOL);
        end
        n_rows++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: t=%0t %s expected %h actual %h", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic drive_row(input int r);
    i_inst  = gold[r][0];
    i_valid = gold[r][1][0];
  endtask

  // offer a word with valid low
  task automatic drive_idle(input int r);
    i_inst  = gold[r][0];
    i_valid = 1'b0;
  endtask

  // an empty slot expects o_valid and the side-effect strobes low
  task automatic check_row(input int r, input bit idle);
    logic [31:0] live;
    live = idle ? 32'd0 : 32'hffff_ffff;
    check_value("o_valid",       gold[r][2] & live,  32'(o_valid));
    check_value("o_alu_op",      gold[r][3],  32'(o_alu_op));
    check_value("o_npc_op",      gold[r][4],  32'(o_npc_op));
    check_value("o_wd_sel",      gold[r][5],  32'(o_wd_sel));
    check_value("o_dm_type",     gold[r][6],  32'(o_dm_type));
    check_value("o_reg_write",   gold[r][7] & live,  32'(o_reg_write));
    check_value("o_mem_write",   gold[r][8] & live,  32'(o_mem_write));
    check_value("o_mem_read",    gold[r][9],  32'(o_mem_read));
    check_value("o_alu_src1",    gold[r][10], 32'(o_alu_src1));
    check_value("o_alu_src2",    gold[r][11], 32'(o_alu_src2));
    check_value("o_csr_write",   gold[r][12] & live, 32'(o_csr_write));
    check_value("o_csr_mask_en", gold[r][13], 32'(o_csr_mask_en));
    check_value("o_ertn",        gold[r][14] & live, 32'(o_ertn));
    check_value("o_syscall",     gold[r][15] & live, 32'(o_syscall));
    check_value("o_imm_alu",     gold[r][16], o_imm_alu);
    check_value("o_imm_pc",      gold[r][17], o_imm_pc);
    check_value("o_rd",          gold[r][18], 32'(o_rd));
    check_value("o_rs1",         gold[r][19], 32'(o_rs1));
    check_value("o_rs2",         gold[r][20], 32'(o_rs2));
    check_value("o_csr_num",     gold[r][21], 32'(o_csr_num));
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_inst  = '0;
    load_golden();
    if (n_rows == 0) begin
      $display("TEST FAILED");
      $fatal(1, "golden file holds no test lines");
    end
    cycle_limit = 2 * n_rows + RST_CYCLES + 20;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      drive_row(r);       // on the falling edge
      @(posedge clk);
      #1;                 // registered outputs settled
      check_row(r, 1'b0);
      @(negedge clk);
      if (gold[r][1][0]) begin
        // next word without valid, row r must hold and write nothing
        drive_idle((r + 1) % n_rows);
        @(posedge clk);
        #1;
        check_row(r, 1'b1);
        @(negedge clk);
      end
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* tb/la_decode_golden.txt */
# inst valid | o_valid alu npc wd dm reg_wr mem_wr mem_rd src1 src2 csr_wr mask ertn syscall
# imm_alu imm_pc rd rs1 rs2 csr_num, all hex, one test per line
00000000 0 0 00 00 0 0 0 0 0 0 0 0 0 0 0 00000000 00000000 00 00 00 0000
001018a4 1 1 03 00 0 0 1 0 0 0 0 0 0 0 0 00000406 00000000 04 05 06 0406
0021bdcd 1 1 1a 00 0 0 1 0 0 0 0 0 0 0 0 fffff86f 00000000 0d 0e 0f 086f
00409441 1 1 0f 00 0 0 1 0 0 0 1 0 0 0 0 00000005 00000000 01 02 05 1025
0048fc83 1 1 11 00 0 0 1 0 0 0 1 0 0 0 0 0000001f 00000000 03 04 1f 123f
02bfe1ac 1 1 03 00 0 0 1 0 0 0 1 0 0 0 0 fffffff8 00000000 0c 0d 18 2ff8
0363c0c5 1 1 0e 00 0 0 1 0 0 0 1 0 0 0 0 000008f0 00000000 05 06 10 18f0
025ffd07 1 1 0b 00 0 0 1 0 0 0 1 0 0 0 0 000007ff 00000000 07 08 1f 17ff
15000029 1 1 01 00 0 0 1 0 0 0 1 0 0 0 0 80001000 00000000 09 01 00 0000
1c00246a 1 1 03 00 0 0 1 0 0 1 1 0 0 0 0 00123000 00000000 0a 03 09 0009
283ffd8b 1 1 03 00 1 3 1 0 1 0 1 0 0 0 0 ffffffff 00000000 0b 0c 1f 0fff
2a4041cd 1 1 03 00 1 2 1 0 1 0 1 0 0 0 0 00000010 00000000 0d 0e 10 1010
295ffa0f 1 1 03 00 0 1 0 1 0 0 1 0 0 0 0 000007fe 00000000 0f 10 0f 17fe
29bff251 1 1 03 00 0 0 0 1 0 0 1 0 0 0 0 fffffffc 00000000 11 12 11 2ffc
001018a4 0 0 03 00 0 0 0 0 0 0 1 0 0 0 0 fffffffc 00000000 11 12 11 2ffc
5bfffa74 1 1 13 01 0 0 0 0 0 0 0 0 0 0 0 fffffff8 fffffff8 14 13 14 3ffe
6c0102b6 1 1 09 01 0 0 0 0 0 0 0 0 0 0 0 00000100 00000100 16 15 16 0040
500003ff 1 1 03 06 0 0 0 0 0 0 0 0 0 0 0 fffc0000 fffc0000 1f 1f 00 0000
54002000 1 1 03 06 2 0 1 0 0 1 1 0 0 0 0 00000004 00000020 01 00 08 0008
4c0042e1 1 1 03 18 2 0 1 0 0 1 1 0 0 0 0 00000004 00000040 01 17 10 0010
04001418 1 1 1b 00 0 0 1 0 0 0 0 0 0 0 0 00000005 00000000 18 00 05 0005
04060039 1 1 1b 00 0 0 1 0 0 0 0 1 0 0 0 00000180 00000000 19 01 19 0180
04c0077a 1 1 1b 00 0 0 1 0 0 0 0 1 1 0 0 00000001 00000000 1a 1b 1a 3001
06483800 1 1 00 08 0 0 1 0 0 0 0 0 0 1 0 0000020e 00000000 00 00 0e 120e
002b0005 1 1 00 00 0 0 1 0 0 0 0 0 0 0 1 fffffac0 00000000 05 00 00 0ac0
ffffffff 1 1 00 00 0 0 0 0 0 0 0 0 0 0 0 ffffffff 00000000 1f 1f 1f 3fff

/* all.f */
rtl/la_decode_pkg.sv
rtl/la_opcode_decode.sv
rtl/la_field_extract.sv
rtl/la_ctrl_gen.sv
rtl/la_id_pipe_reg.sv
rtl/la_decode_top.sv
tb/tb_la_decode.sv

/* run.sh */
#!/bin/sh
# build and run the decode testbench, exit status is the simulation result
cd "$(dirname "$0")" \
  && verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_la_decode \
       -f all.f -o tb_la_decode \
  && ./obj_dir/tb_la_decode || exit 1
